// ==== runSim.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module cpuTb \
        -f sources.f -o cpuSim \
    && ./obj_dir/cpuSim \
    || exit 1

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit #(parameter int dataWidth = 32) (
    input datapathPkg::aluOpT aluOp,
    input logic [dataWidth-1:0] a,
    input logic [dataWidth-1:0] b,
    output logic [2*dataWidth-1:0] result
);
    import datapathPkg::*;

    localparam int shiftBits = $clog2(dataWidth);

    logic [shiftBits-1:0] shamt;
    logic [dataWidth-1:0] low;
    logic signed [2*dataWidth-1:0] product;

    assign shamt = b[shiftBits-1:0];
    assign product = $signed(a) * $signed(b);

    always_comb begin
        case (aluOp)
            aluAdd: low = a + b;
            aluSub: low = a - b;
            aluAnd: low = a & b;
            aluOr: low = a | b;
            aluShr: low = a >> shamt;
            aluShra: low = $signed(a) >>> shamt;
            aluShl: low = a << shamt;
            aluRor: low = (a >> shamt) | (a << (dataWidth - shamt));
            aluRol: low = (a << shamt) | (a >> (dataWidth - shamt));
            // Unary ops work on the bus operand
            aluNeg: low = -b;
            aluNot: low = ~b;
            default: low = b;
        endcase
    end

    // Only multiply fills the upper half
    assign result = (aluOp == aluMul) ? product : {{dataWidth{1'b0}}, low};

endmodule

// ==== source/controlBus.sv ====
`timescale 1ns/1ps

interface controlBus #(parameter int dataWidth = 32);
    import datapathPkg::*;

    busSourceT busSource;
    aluOpT aluOp;
    logic marIn, mdrIn, mdrFromMem, pcIn, incPc, irIn;
    logic yIn, zIn, hiIn, loIn, conIn, outIn;
    logic gra, grb, grc, rIn, baOut;
    logic memWrite;

    // Status back from the datapath
    logic [dataWidth-1:0] ir;
    logic conFlag;

    modport control (
        output busSource, aluOp, marIn, mdrIn, mdrFromMem, pcIn, incPc, irIn,
        output yIn, zIn, hiIn, loIn, conIn, outIn,
        output gra, grb, grc, rIn, baOut, memWrite,
        input ir, conFlag
    );

    modport path (
        input busSource, aluOp, marIn, mdrIn, mdrFromMem, pcIn, incPc, irIn,
        input yIn, zIn, hiIn, loIn, conIn, outIn,
        input gra, grb, grc, rIn, baOut,
        output ir, conFlag
    );

endinterface

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input logic clk,
    input logic reset,
    controlBus.control ctl,
    input datapathPkg::stepT step,
    output logic advance,
    output logic finish,
    output logic halt,
    output logic memReqValid,
    input logic memReqReady,
    input logic memRspValid
);
    import isaPkg::*;
    import datapathPkg::*;

    opcodeT opcode;
    aluOpT opAlu;
    stepT lastStep;
    logic [7:0] at;
    logic running, reqIssued, memStep, addrCalc;
    logic isLoad, isLoadImm, isStore, isAluReg, isAluImm, isMul, isUnary;
    logic isBranch, isJr, isJal, isIn, isOut, isMfhi, isMflo, isHalt;

    // Idle for one cycle out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            reqIssued <= 1'b0;
        end else begin
            running <= 1'b1;
            if (memRspValid) begin
                reqIssued <= 1'b0;
            end else if (memReqValid && memReqReady) begin
                reqIssued <= 1'b1;
            end
        end
    end

    assign opcode = opcodeT'(ctl.ir[opMsb:opLsb]);

    always_comb begin
        {isLoad, isLoadImm, isStore, isAluReg, isAluImm, isMul, isUnary} = '0;
        {isBranch, isJr, isJal, isIn, isOut, isMfhi, isMflo, isHalt} = '0;
        case (opcode)
            opLd: isLoad = 1'b1;
            opLdi: isLoadImm = 1'b1;
            opSt: isStore = 1'b1;
            opAdd, opSub, opShr, opShra, opShl, opRor, opRol, opAnd, opOr: isAluReg = 1'b1;
            opAddi, opAndi, opOri: isAluImm = 1'b1;
            opMul: isMul = 1'b1;
            opNeg, opNot: isUnary = 1'b1;
            opBr: isBranch = 1'b1;
            opJr: isJr = 1'b1;
            opJal: isJal = 1'b1;
            opIn: isIn = 1'b1;
            opOut: isOut = 1'b1;
            opMfhi: isMfhi = 1'b1;
            opMflo: isMflo = 1'b1;
            opHalt: isHalt = 1'b1;
            // Divide is not built
            opNop, opDiv: ;
            default: ;
        endcase

        case (opcode)
            opSub: opAlu = aluSub;
            opShr: opAlu = aluShr;
            opShra: opAlu = aluShra;
            opShl: opAlu = aluShl;
            opRor: opAlu = aluRor;
            opRol: opAlu = aluRol;
            opAnd, opAndi: opAlu = aluAnd;
            opOr, opOri: opAlu = aluOr;
            opMul: opAlu = aluMul;
            opNeg: opAlu = aluNeg;
            opNot: opAlu = aluNot;
            default: opAlu = aluAdd;
        endcase

        if (isJal || isUnary) begin
            lastStep = stepT4;
        end else if (isLoadImm || isAluReg || isAluImm) begin
            lastStep = stepT5;
        end else if (isMul || isBranch) begin
            lastStep = stepT6;
        end else if (isLoad || isStore) begin
            lastStep = stepT7;
        end else begin
            lastStep = stepT3;
        end
    end

    assign addrCalc = isLoad || isLoadImm || isStore;
    assign at = running ? (8'd1 << step) : 8'd0;

    always_comb begin
        if (at[0] || (at[3] && isJal) || (at[4] && isBranch)) begin
            ctl.busSource = busPc;
        end else if (at[2] || (at[7] && isLoad)) begin
            ctl.busSource = busMdr;
        end else if (at[3] && isMfhi) begin
            ctl.busSource = busHi;
        end else if (at[3] && isMflo) begin
            ctl.busSource = busLo;
        end else if (at[3] && isIn) begin
            ctl.busSource = busInPort;
        end else if (at[5] && isMul) begin
            ctl.busSource = busZHi;
        end else if ((at[4] && isUnary) || (at[5] && (addrCalc || isAluReg || isAluImm))
                     || (at[6] && (isMul || isBranch))) begin
            ctl.busSource = busZLo;
        end else if ((at[4] && (addrCalc || isAluImm)) || (at[5] && isBranch)) begin
            ctl.busSource = busConst;
        end else begin
            ctl.busSource = busReg;
        end
    end

    // Per-step strobes
    assign ctl.marIn = at[0] || (at[5] && (isLoad || isStore));
    assign ctl.incPc = at[0];
    assign ctl.mdrFromMem = at[1] || (at[6] && isLoad);
    assign ctl.mdrIn = ctl.mdrFromMem || (at[6] && isStore);
    assign ctl.irIn = at[2];
    assign ctl.yIn = (at[3] && (addrCalc || isAluReg || isAluImm || isMul))
                     || (at[4] && isBranch);
    assign ctl.zIn = (at[3] && isUnary) || (at[4] && (addrCalc || isAluReg || isAluImm || isMul))
                     || (at[5] && isBranch);
    assign ctl.aluOp = ctl.zIn ? opAlu : aluPass;
    assign ctl.pcIn = (at[3] && isJr) || (at[4] && isJal) || (at[6] && isBranch && ctl.conFlag);
    assign ctl.hiIn = at[5] && isMul;
    assign ctl.loIn = at[6] && isMul;
    assign ctl.conIn = at[3] && isBranch;
    assign ctl.outIn = at[3] && isOut;
    assign ctl.gra = (at[3] && (isBranch || isJr || isIn || isOut || isMfhi || isMflo))
                     || (at[4] && (isMul || isUnary || isJal))
                     || (at[5] && (isLoadImm || isAluReg || isAluImm))
                     || (at[6] && isStore) || (at[7] && isLoad);
    assign ctl.grb = at[3] && (addrCalc || isAluReg || isAluImm || isMul || isUnary || isJal);
    assign ctl.grc = at[4] && isAluReg;
    assign ctl.rIn = (at[3] && (isJal || isIn || isMfhi || isMflo)) || (at[4] && isUnary)
                     || (at[5] && (isLoadImm || isAluReg || isAluImm)) || (at[7] && isLoad);
    assign ctl.baOut = at[3] && addrCalc;
    assign ctl.memWrite = at[7] && isStore;

    // Memory steps hold until the response
    assign memStep = at[1] || (at[6] && isLoad) || (at[7] && isStore);
    assign memReqValid = memStep && !reqIssued;
    assign advance = running && (!memStep || memRspValid);
    assign finish = advance && (step == lastStep) && !isHalt;
    assign halt = at[3] && isHalt;

    // One bus source, and the register file never feeds itself
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({ctl.gra, ctl.grb, ctl.grc}) && !(ctl.rIn && ctl.busSource == busReg));

    assert property (@(posedge clk) disable iff (reset)
        (memReqValid && !memReqReady) |=> memReqValid);

endmodule

// ==== source/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop #(
    parameter int dataWidth = 32,
    parameter int addrWidth = 9
) (
    input logic clk,
    input logic reset,
    output logic memReqValid,
    input logic memReqReady,
    output logic [addrWidth-1:0] memAddr,
    output logic memWrite,
    output logic [dataWidth-1:0] memWriteData,
    input logic memRspValid,
    input logic [dataWidth-1:0] memReadData,
    input logic [dataWidth-1:0] inPort,
    output logic [dataWidth-1:0] outPort,
    output logic outStrobe,
    output logic halted,
    output logic [15:0] retiredCount
);
    import datapathPkg::*;

    stepT step;
    logic advance, finish;

    controlBus #(.dataWidth(dataWidth)) ctlBus ();

    controlUnit control (
        .clk(clk), .reset(reset), .ctl(ctlBus.control), .step(step),
        .advance(advance), .finish(finish), .halt(halted),
        .memReqValid(memReqValid), .memReqReady(memReqReady), .memRspValid(memRspValid)
    );

    stepCounter steps (
        .clk(clk), .reset(reset), .advance(advance), .finish(finish), .halt(halted),
        .step(step), .retiredCount(retiredCount)
    );

    datapath #(.dataWidth(dataWidth), .addrWidth(addrWidth)) path (
        .clk(clk), .reset(reset), .ctl(ctlBus.path),
        .inPort(inPort), .outPort(outPort), .outStrobe(outStrobe),
        .memAddr(memAddr), .memWriteData(memWriteData),
        .memReadData(memReadData), .memRspValid(memRspValid)
    );

    assign memWrite = ctlBus.memWrite;

endmodule

// ==== source/datapath.sv ====
`timescale 1ns/1ps

module datapath #(
    parameter int dataWidth = 32,
    parameter int addrWidth = 9
) (
    input logic clk,
    input logic reset,
    controlBus.path ctl,
    input logic [dataWidth-1:0] inPort,
    output logic [dataWidth-1:0] outPort,
    output logic outStrobe,
    output logic [addrWidth-1:0] memAddr,
    output logic [dataWidth-1:0] memWriteData,
    input logic [dataWidth-1:0] memReadData,
    input logic memRspValid
);
    import isaPkg::*;
    import datapathPkg::*;

    localparam int cWidth = cMsb - cLsb + 1;

    logic [dataWidth-1:0] bus, regOut, pc, ir, mdr, y, hi, lo, inReg, cExt;
    logic [2*dataWidth-1:0] z, aluResult;
    logic [addrWidth-1:0] mar;
    logic conFlag, condMet;

    registerFile #(.dataWidth(dataWidth)) regFile (
        .clk(clk), .reset(reset), .ir(ir),
        .gra(ctl.gra), .grb(ctl.grb), .grc(ctl.grc), .rIn(ctl.rIn), .baOut(ctl.baOut),
        .busIn(bus), .regOut(regOut)
    );

    aluUnit #(.dataWidth(dataWidth)) alu (
        .aluOp(ctl.aluOp), .a(y), .b(bus), .result(aluResult)
    );

    assign cExt = {{(dataWidth - cWidth){ir[cMsb]}}, ir[cMsb:cLsb]};

    always_comb begin
        case (ctl.busSource)
            busHi: bus = hi;
            busLo: bus = lo;
            busZHi: bus = z[2*dataWidth-1:dataWidth];
            busZLo: bus = z[dataWidth-1:0];
            busPc: bus = pc;
            busMdr: bus = mdr;
            busInPort: bus = inReg;
            busConst: bus = cExt;
            default: bus = regOut;
        endcase
    end

    // Branch test on the register driven in T3
    always_comb begin
        case (branchCondT'(ir[condMsb:condLsb]))
            condZero: condMet = (bus == '0);
            condNonZero: condMet = (bus != '0);
            condPositive: condMet = !bus[dataWidth-1] && (bus != '0);
            default: condMet = bus[dataWidth-1];
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
            ir <= '0;
            conFlag <= 1'b0;
            outPort <= '0;
            outStrobe <= 1'b0;
        end else begin
            if (ctl.pcIn) begin
                pc <= bus;
            end else if (ctl.incPc) begin
                pc <= pc + 1'b1;
            end
            if (ctl.irIn) begin
                ir <= bus;
            end
            if (ctl.conIn) begin
                conFlag <= condMet;
            end
            if (ctl.outIn) begin
                outPort <= bus;
            end
            outStrobe <= ctl.outIn;
        end
    end

    always_ff @(posedge clk) begin
        inReg <= inPort;
        if (ctl.marIn) mar <= bus[addrWidth-1:0];
        if (ctl.yIn) y <= bus;
        if (ctl.zIn) z <= aluResult;
        if (ctl.hiIn) hi <= bus;
        if (ctl.loIn) lo <= bus;
        // Memory loads wait for the response pulse
        if (ctl.mdrIn && !ctl.mdrFromMem) begin
            mdr <= bus;
        end else if (ctl.mdrIn && memRspValid) begin
            mdr <= memReadData;
        end
    end

    assign memAddr = mar;
    assign memWriteData = mdr;
    assign ctl.ir = ir;
    assign ctl.conFlag = conFlag;

endmodule

// ==== source/datapathPkg.sv ====
package datapathPkg;

    // Single driver of the internal bus
    typedef enum logic [3:0] {
        busReg, busHi, busLo, busZHi, busZLo, busPc, busMdr, busInPort, busConst
    } busSourceT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr,
        aluShr, aluShra, aluShl, aluRor, aluRol,
        aluMul, aluNeg, aluNot, aluPass
    } aluOpT;

    typedef enum logic [2:0] {
        stepT0, stepT1, stepT2, stepT3, stepT4, stepT5, stepT6, stepT7
    } stepT;

endpackage

// ==== source/isaPkg.sv ====
package isaPkg;

    // Instruction opcodes
    typedef enum logic [4:0] {
        opLd = 5'd0, opLdi, opSt,
        opAdd, opSub, opShr, opShra, opShl, opRor, opRol, opAnd, opOr,
        opAddi, opAndi, opOri,
        opMul, opDiv, opNeg, opNot,
        opBr, opJr, opJal,
        opIn, opOut, opMfhi, opMflo,
        opNop, opHalt
    } opcodeT;

    // Instruction fields
    localparam int opMsb = 31;
    localparam int opLsb = 27;
    localparam int raMsb = 26;
    localparam int raLsb = 23;
    localparam int rbMsb = 22;
    localparam int rbLsb = 19;
    localparam int rcMsb = 18;
    localparam int rcLsb = 15;
    localparam int cMsb = 18;
    localparam int cLsb = 0;
    localparam int condMsb = 20;
    localparam int condLsb = 19;

    typedef enum logic [1:0] {
        condZero,
        condNonZero,
        condPositive,
        condNegative
    } branchCondT;

endpackage

// ==== source/registerFile.sv ====
`timescale 1ns/1ps

module registerFile #(parameter int dataWidth = 32) (
    input logic clk,
    input logic reset,
    input logic [dataWidth-1:0] ir,
    input logic gra,
    input logic grb,
    input logic grc,
    input logic rIn,
    input logic baOut,
    input logic [dataWidth-1:0] busIn,
    output logic [dataWidth-1:0] regOut
);
    import isaPkg::*;

    logic [dataWidth-1:0] regs [16];
    logic [3:0] sel;

    always_comb begin
        if (gra) begin
            sel = ir[raMsb:raLsb];
        end else if (grb) begin
            sel = ir[rbMsb:rbLsb];
        end else if (grc) begin
            sel = ir[rcMsb:rcLsb];
        end else begin
            sel = 4'd0;
        end
    end

    // Base of zero for direct addressing
    assign regOut = (baOut && sel == 4'd0) ? '0 : regs[sel];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[sel] <= busIn;
        end
    end

endmodule

// ==== source/stepCounter.sv ====
`timescale 1ns/1ps

module stepCounter (
    input logic clk,
    input logic reset,
    input logic advance,
    input logic finish,
    input logic halt,
    output datapathPkg::stepT step,
    output logic [15:0] retiredCount
);
    import datapathPkg::*;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step <= stepT0;
            retiredCount <= '0;
        end else if (!halt) begin
            if (finish) begin
                step <= stepT0;
                retiredCount <= retiredCount + 16'd1;
            end else if (advance) begin
                step <= stepT'(step + 3'd1);
            end
        end
    end

    // Leaving T7 must retire the instruction
    assert property (@(posedge clk) disable iff (reset)
        (step == stepT7 && advance && !halt) |-> finish);

endmodule

// ==== sources.f ====
source/isaPkg.sv
source/datapathPkg.sv
source/controlBus.sv
source/controlUnit.sv
source/stepCounter.sv
source/registerFile.sv
source/aluUnit.sv
source/datapath.sv
source/cpuTop.sv
test/clockGen.sv
test/cpuTb.sv

// ==== test/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset covers the first 16 rising edges
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== test/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;
    import isaPkg::*;

    localparam int progLen = 60;
    localparam int cycleLimit = progLen * (8 + 2 * 8) * 2;

    typedef enum int {
        kAlu, kImm, kLdi, kMul, kUnary, kHiLo, kLoad, kStore, kIn, kOut, kBranch, kNop,
        kTarget, kJump
    } kindT;

    logic clk, reset;
    logic memReqValid, memReqReady, memWrite, memRspValid, outStrobe, halted;
    logic [8:0] memAddr;
    logic [31:0] memWriteData, memReadData, inPort, outPort;
    logic [15:0] retiredCount;

    logic [31:0] mem [512];
    logic [31:0] modelMem [512];
    logic [31:0] inValues [progLen];
    kindT kind [progLen];
    logic [31:0] expOuts [$];
    logic [8:0] expStoreAddr [$];
    logic [31:0] expStoreData [$];
    int modelCount;

    clockGen clocks (.clk(clk), .reset(reset));

    cpuTop #(.dataWidth(32), .addrWidth(9)) uut (
        .clk(clk), .reset(reset),
        .memReqValid(memReqValid), .memReqReady(memReqReady), .memAddr(memAddr),
        .memWrite(memWrite), .memWriteData(memWriteData),
        .memRspValid(memRspValid), .memReadData(memReadData),
        .inPort(inPort), .outPort(outPort), .outStrobe(outStrobe),
        .halted(halted), .retiredCount(retiredCount)
    );

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic badValue(string name, logic [31:0] got, logic [31:0] expected);
        failRun($sformatf("ERR %s got %h expected %h", name, got, expected));
    endtask

    function automatic logic [31:0] encode(logic [4:0] op, int ra, int rb, int rc, int c);
        logic [31:0] w;
        w = {op, 4'(ra), 4'(rb), 19'(c)};
        w[18:15] = w[18:15] | 4'(rc);
        return w;
    endfunction

    // Forward target that never lands on the jump half of a pair
    function automatic int nextTarget(int from);
        int t;
        t = from + int'($urandom % 6);
        if (t > progLen - 1) begin
            t = progLen - 1;
        end
        while (kind[t] == kJump) begin
            t++;
        end
        return t;
    endfunction

    function automatic bit conditionHolds(logic [1:0] cond, logic [31:0] v);
        case (branchCondT'(cond))
            condZero: return v == 32'd0;
            condNonZero: return v != 32'd0;
            condPositive: return !v[31] && v != 32'd0;
            default: return v[31];
        endcase
    endfunction

    task automatic buildProgram();
        int a, i, r, t, ra, rb;
        logic [4:0] op;
        for (a = 0; a < 512; a++) begin
            mem[a] = (a < 256) ? {opHalt, 27'(a)} : 32'(a) * 32'h9E3779B1;
        end
        for (i = 0; i < progLen; i++) begin
            kind[i] = kNop;
            inValues[i] = $urandom;
        end
        // R1 is the data base, R4..R7 seeded, then HI and LO set once
        mem[0] = encode(opLdi, 1, 0, 0, 256);
        for (i = 1; i < 5; i++) begin
            mem[i] = encode(opLdi, i + 3, 0, 0, int'($urandom));
        end
        mem[5] = encode(opMul, 4, 5, 0, 0);
        mem[progLen - 1] = encode(opHalt, 0, 0, 0, 0);
        i = 6;
        while (i < progLen - 1) begin
            r = int'($urandom % 16);
            if (r >= 14 && i < progLen - 2) begin
                kind[i] = kTarget;
                kind[i + 1] = kJump;
                i += 2;
            end else begin
                kind[i] = (r >= 12) ? kOut : kindT'(r);
                i++;
            end
        end
        for (i = 6; i < progLen - 1; i++) begin
            ra = 4 + int'($urandom % 12);
            rb = int'($urandom % 16);
            case (kind[i])
                kAlu: mem[i] = encode(5'(opAdd + $urandom % 9), ra, rb, int'($urandom % 16), 0);
                kImm: mem[i] = encode(5'(opAddi + $urandom % 3), ra, rb, 0, int'($urandom));
                kLdi: mem[i] = encode(opLdi, ra, rb, 0, int'($urandom));
                kMul: mem[i] = encode(opMul, int'($urandom % 16), rb, 0, 0);
                kUnary: mem[i] = encode(5'(opNeg + $urandom % 2), ra, rb, 0, 0);
                kHiLo: mem[i] = encode(5'(opMfhi + $urandom % 2), ra, 0, 0, 0);
                kLoad, kStore: begin
                    op = (kind[i] == kLoad) ? opLd : opSt;
                    if (kind[i] == kStore) begin
                        ra = rb;
                    end
                    if ($urandom % 2 == 0) begin
                        mem[i] = encode(op, ra, 0, 0, 256 + int'($urandom % 256));
                    end else begin
                        mem[i] = encode(op, ra, 1, 0, int'($urandom % 256));
                    end
                end
                kIn: mem[i] = encode(opIn, ra, 0, 0, 0);
                kOut: mem[i] = encode(opOut, rb, 0, 0, 0);
                kBranch: begin
                    t = nextTarget(i + 1);
                    mem[i] = encode(opBr, rb, int'($urandom % 4), 0, t - i - 1);
                end
                kTarget: begin
                    t = nextTarget(i + 2);
                    if ($urandom % 2 == 0) begin
                        mem[i] = encode(opLdi, 2, 0, 0, t);
                        mem[i + 1] = encode(opJr, 2, 0, 0, 0);
                    end else begin
                        mem[i] = encode(opLdi, 3, 0, 0, t);
                        mem[i + 1] = encode(opJal, 3, ra, 0, 0);
                    end
                end
                kJump: ;
                default: mem[i] = encode(opNop, 0, 0, 0, 0);
            endcase
        end
    endtask

    // Instruction-level interpreter of the program
    task automatic runModel();
        logic [31:0] regs [16];
        logic [31:0] pc, w, a, b, base, c, hi, lo;
        logic [63:0] wide;
        logic signed [63:0] product;
        logic [8:0] addr;
        int i, ra, rb, rc, instrAddr, executed;
        bit running;
        for (i = 0; i < 16; i++) begin
            regs[i] = 32'd0;
        end
        for (i = 0; i < 512; i++) begin
            modelMem[i] = mem[i];
        end
        hi = 32'd0;
        lo = 32'd0;
        pc = 32'd0;
        modelCount = 0;
        executed = 0;
        running = 1'b1;
        while (running) begin
            instrAddr = int'(pc[8:0]);
            w = modelMem[instrAddr];
            ra = int'(w[26:23]);
            rb = int'(w[22:19]);
            rc = int'(w[18:15]);
            c = {{13{w[18]}}, w[18:0]};
            base = (rb == 0) ? 32'd0 : regs[rb];
            addr = 9'(base + c);
            a = regs[rb];
            b = regs[rc];
            pc = pc + 32'd1;
            modelCount++;
            executed++;
            if (executed > progLen) begin
                failRun("model ran past the end of the program");
            end
            case (opcodeT'(w[31:27]))
                opLd: regs[ra] = modelMem[addr];
                opLdi: regs[ra] = base + c;
                opSt: begin
                    modelMem[addr] = regs[ra];
                    expStoreAddr.push_back(addr);
                    expStoreData.push_back(regs[ra]);
                end
                opAdd: regs[ra] = a + b;
                opSub: regs[ra] = a - b;
                opAnd: regs[ra] = a & b;
                opOr: regs[ra] = a | b;
                opShr: regs[ra] = a >> b[4:0];
                opShra: regs[ra] = $signed(a) >>> b[4:0];
                opShl: regs[ra] = a << b[4:0];
                opRor: begin
                    wide = {a, a} >> b[4:0];
                    regs[ra] = wide[31:0];
                end
                opRol: begin
                    wide = {a, a} << b[4:0];
                    regs[ra] = wide[63:32];
                end
                opAddi: regs[ra] = a + c;
                opAndi: regs[ra] = a & c;
                opOri: regs[ra] = a | c;
                opMul: begin
                    product = $signed(regs[rb]) * $signed(regs[ra]);
                    hi = product[63:32];
                    lo = product[31:0];
                end
                opNeg: regs[ra] = -a;
                opNot: regs[ra] = ~a;
                opBr: begin
                    if (conditionHolds(w[20:19], regs[ra])) begin
                        pc = pc + c;
                    end
                end
                opJr: pc = regs[ra];
                opJal: begin
                    regs[rb] = pc;
                    pc = regs[ra];
                end
                opIn: regs[ra] = inValues[instrAddr];
                opOut: expOuts.push_back(regs[ra]);
                opMfhi: regs[ra] = hi;
                opMflo: regs[ra] = lo;
                opHalt: begin
                    running = 1'b0;
                    modelCount--;
                end
                default: ;
            endcase
        end
    endtask

    initial begin
        int cycles, rspDelay, burst, storeIndex, outIndex;
        bit pending, held, reqWrite;
        logic [8:0] reqAddr, heldAddr;
        cycles = 0;
        rspDelay = 0;
        burst = 0;
        storeIndex = 0;
        outIndex = 0;
        pending = 1'b0;
        held = 1'b0;
        reqWrite = 1'b0;
        reqAddr = '0;
        heldAddr = '0;
        memReqReady = 1'b0;
        memRspValid = 1'b0;
        memReadData = 32'd0;
        inPort = 32'd0;
        void'($urandom(32'h18188800));
        buildProgram();
        runModel();
        wait (reset === 1'b0);
        while (!halted) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > cycleLimit) begin
                failRun("timeout: the core did not halt within the cycle limit");
            end
            if (outStrobe) begin
                assert (outIndex < expOuts.size())
                    else failRun("out write that the model does not expect");
                assert (outPort == expOuts[outIndex])
                    else badValue("outPort", outPort, expOuts[outIndex]);
                outIndex++;
            end
            memRspValid = 1'b0;
            if (pending) begin
                rspDelay--;
                if (rspDelay == 0) begin
                    pending = 1'b0;
                    memRspValid = 1'b1;
                    if (!reqWrite) begin
                        memReadData = mem[reqAddr];
                        // New input value ahead of each fetched in
                        if (reqAddr < 9'(progLen)) begin
                            inPort = inValues[reqAddr];
                        end
                    end
                end
            end
            if (held) begin
                assert (memReqValid)
                    else failRun("memReqValid dropped before the request was taken");
                assert (memAddr == heldAddr)
                    else badValue("memAddr", 32'(memAddr), 32'(heldAddr));
            end
            if (burst > 0) begin
                burst--;
            end else if ($urandom % 8 == 0) begin
                burst = 2 + int'($urandom % 7);
            end
            memReqReady = (burst == 0) && ($urandom % 4 != 0);
            held = memReqValid && !memReqReady;
            heldAddr = memAddr;
            if (memReqValid && memReqReady) begin
                assert (!pending)
                    else failRun("second memory request while one is outstanding");
                pending = 1'b1;
                rspDelay = 1 + int'($urandom % 4);
                reqAddr = memAddr;
                reqWrite = memWrite;
                if (memWrite) begin
                    assert (storeIndex < expStoreAddr.size())
                        else failRun("store that the model does not expect");
                    assert (memAddr == expStoreAddr[storeIndex])
                        else badValue("memAddr", 32'(memAddr), 32'(expStoreAddr[storeIndex]));
                    assert (memWriteData == expStoreData[storeIndex])
                        else badValue("memWriteData", memWriteData, expStoreData[storeIndex]);
                    storeIndex++;
                    mem[memAddr] = memWriteData;
                end
            end
        end
        assert (outIndex == expOuts.size())
            else failRun("fewer out writes than the model expects");
        assert (storeIndex == expStoreAddr.size())
            else failRun("fewer stores than the model expects");
        assert (retiredCount == 16'(modelCount))
            else badValue("retiredCount", 32'(retiredCount), 32'(modelCount));
        memReqReady = 1'b1;
        repeat (20) begin
            @(posedge clk);
            #1;
            assert (!memReqValid) else failRun("memory request issued after halt");
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule
